/* Makefile */
# Verilator build and run for the word game engine

VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TOP        ?= wordGameTb
RTL_TOP    ?= wordGame
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= -Wall
PASS_TEXT  ?= test passed

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* common/gamePkg.sv */
/*
 * Shared definitions for the word game engine:
 * data widths, game limits, Wishbone register map,
 * status word bit positions and the guess result code.
 */
package gamePkg;

    // game geometry
    localparam int WORD_LEN     = 5;
    localparam int ALPHA_LEN    = 26;
    localparam int MAX_MISTAKES = 6;

    // lowercase ASCII bounds
    localparam logic [7:0] LETTER_A = 8'h61;
    localparam logic [7:0] LETTER_Z = 8'h7a;

    typedef logic [7:0]              letter_t;
    typedef logic [WORD_LEN*8-1:0]   word_t;
    typedef logic [WORD_LEN-1:0]     posMask_t;
    typedef logic [ALPHA_LEN-1:0]    alphaMask_t;
    typedef logic [2:0]              mistakes_t;
    typedef logic [31:0]             wbData_t;
    typedef logic [1:0]              wbAddr_t;

    // register map, word addresses
    localparam wbAddr_t ADDR_WORD0  = 2'd0;
    localparam wbAddr_t ADDR_WORD1  = 2'd1;
    localparam wbAddr_t ADDR_GUESS  = 2'd2;
    localparam wbAddr_t ADDR_STATUS = 2'd3;

    // status word field positions
    localparam int ST_FOUND_LSB    = 0;
    localparam int ST_MISTAKES_LSB = 8;
    localparam int ST_RESULT_LSB   = 16;
    localparam int ST_WON_BIT      = 24;
    localparam int ST_LOST_BIT     = 25;
    localparam int ST_ACTIVE_BIT   = 26;

    typedef enum logic [2:0] {
        RES_NONE    = 3'd0,
        RES_HIT     = 3'd1,
        RES_MISS    = 3'd2,
        RES_REPEAT  = 3'd3,
        RES_INVALID = 3'd4,
        RES_OVER    = 3'd5
    } result_e;

endpackage

/* dv/wordGameTb.sv */
/*
 * Directed testbench for the word game engine.
 * Clock and reset, Wishbone master tasks, reference model of the
 * game rules, directed and LFSR driven tests, watchdog.
 */
`timescale 1ns/1ps

module wordGameTb;
    import gamePkg::*;

    localparam int CLK_PERIOD       = 40;
    localparam int DIRECTED_GAMES   = 5;
    localparam int DIRECTED_GUESSES = 30;
    localparam int RAND_GAMES       = 8;
    localparam int RAND_GUESSES     = 14;
    localparam int TOTAL_GUESSES    = DIRECTED_GUESSES + RAND_GAMES * RAND_GUESSES + 2;
    // a guess is a write plus a status read, a game start two writes plus a read
    localparam int TOTAL_ACCESSES   = 2 * TOTAL_GUESSES
                                    + 3 * (DIRECTED_GAMES + RAND_GAMES + 1) + 4;
    localparam int WATCHDOG_NS      = (TOTAL_ACCESSES * 10 + 20) * CLK_PERIOD;

    logic    clk;
    logic    nRst;
    logic    cyc;
    logic    stb;
    logic    we;
    wbAddr_t adr;
    wbData_t datIn;
    wbData_t datOut;
    logic    ack;

    // reference model state
    letter_t    expWord [WORD_LEN];
    posMask_t   expFound;
    mistakes_t  expMistakes;
    result_e    expResult;
    logic       expWon;
    logic       expLost;
    logic       expActive;
    alphaMask_t expTried;

    logic [31:0] lfsr = 32'h78fc_2478;
    int          checks = 0;
    int          errors = 0;

    wordGame u_wordGame (
        .clk(clk), .nRst(nRst),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datIn(datIn), .datOut(datOut), .ack(ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic int unsigned randBits(input int n);
        int unsigned v;
        logic        fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = (v << 1) | fb;
        end
        return v;
    endfunction

    function automatic letter_t randomLetter();
        return letter_t'(8'h61 + randBits(5) % 26);
    endfunction

    // the top six codes land on non-letters just below 'a'
    function automatic letter_t randomGuess();
        int unsigned v;
        v = randBits(5);
        if (v < 26) return letter_t'(8'h61 + v);
        else return letter_t'(8'h5a + v - 26);
    endfunction

    function automatic word_t packWord(input string s);
        word_t w;
        for (int i = 0; i < WORD_LEN; i++) w[i*8 +: 8] = s[i];
        return w;
    endfunction

    function automatic wbData_t expectedStatus();
        wbData_t s;
        s        = '0;
        s[4:0]   = expFound;
        s[10:8]  = expMistakes;
        s[18:16] = expResult;
        s[24]    = expWon;
        s[25]    = expLost;
        s[26]    = expActive;
        return s;
    endfunction

    task automatic wbWrite(input wbAddr_t a, input wbData_t d);
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        datIn = d;
        @(negedge clk);
        while (!ack) @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wbRead(input wbAddr_t a, output wbData_t d);
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        @(negedge clk);
        while (!ack) @(negedge clk);
        d   = datOut;
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    // scoring rules in priority order
    task automatic modelGuess(input letter_t g);
        posMask_t hits;
        int       idx;
        if (!expActive) begin
            expResult = RES_OVER;
        end else if (g < 8'h61 || g > 8'h7a) begin
            expResult = RES_INVALID;
        end else begin
            idx = g - 8'h61;
            if (expTried[idx]) begin
                expResult = RES_REPEAT;
            end else begin
                expTried[idx] = 1'b1;
                for (int i = 0; i < WORD_LEN; i++) hits[i] = (expWord[i] == g);
                if (hits != '0) begin
                    expFound  = expFound | hits;
                    expResult = RES_HIT;
                end else begin
                    expMistakes = expMistakes + 1'b1;
                    expResult   = RES_MISS;
                end
                expWon    = (expFound == 5'b11111);
                expLost   = (expMistakes == 3'd6);
                expActive = !(expWon || expLost);
            end
        end
    endtask

    task automatic checkStatus(input string what);
        wbData_t st;
        wbData_t exp;
        wbRead(ADDR_STATUS, st);
        exp = expectedStatus();
        checks++;
        assert (st == exp) else begin
            $display("ERR %0t: %s status %h, expected %h", $time, what, st, exp);
            errors++;
        end
    endtask

    task automatic startGame(input word_t w);
        wbWrite(ADDR_WORD0, w[31:0]);
        wbWrite(ADDR_WORD1, {24'h0, w[39:32]});
        for (int i = 0; i < WORD_LEN; i++) expWord[i] = w[i*8 +: 8];
        expFound    = '0;
        expMistakes = '0;
        expResult   = RES_NONE;
        expWon      = 1'b0;
        expLost     = 1'b0;
        expActive   = 1'b1;
        expTried    = '0;
    endtask

    task automatic playGuess(input letter_t g);
        wbWrite(ADDR_GUESS, {24'h0, g});
        modelGuess(g);
        checkStatus($sformatf("guess %h", g));
    endtask

    task automatic reportTest(input string name, input int errsBefore);
        $display("%s: %0d errors", name, errors - errsBefore);
    endtask

    task automatic afterReset();
        wbData_t st;
        int      e0;
        e0 = errors;
        checkStatus("after reset");
        startGame(packWord("plant"));
        checkStatus("new word");
        // word registers hold a nonzero word now but are write only
        wbRead(ADDR_WORD0, st);
        checks++;
        assert (st == '0) else begin
            $display("ERR %0t: word register read back %h, expected 0", $time, st);
            errors++;
        end
        reportTest("reset and start", e0);
    endtask

    task automatic hitsAndMisses();
        int e0;
        e0 = errors;
        // 'e' sits at three positions
        startGame(packWord("eerie"));
        playGuess("e");
        playGuess("z");
        playGuess("q");
        playGuess("r");
        reportTest("hits and misses", e0);
    endtask

    task automatic repeatsAndInvalids();
        int e0;
        e0 = errors;
        startGame(packWord("media"));
        playGuess("a");
        playGuess("a");
        playGuess(8'h41);
        // low five bits of 8'h31 - 'a' point at 'q', guessed below
        playGuess(8'h31);
        playGuess(8'h7b);
        playGuess(8'h60);
        playGuess(8'hff);
        playGuess("m");
        playGuess("m");
        playGuess("q");
        reportTest("repeats and invalids", e0);
    endtask

    task automatic winAndLoss();
        int e0;
        e0 = errors;
        startGame(packWord("crane"));
        playGuess("c");
        playGuess("r");
        playGuess("a");
        playGuess("n");
        playGuess("e");
        playGuess("x");
        playGuess("c");
        startGame(packWord("crane"));
        playGuess("b");
        playGuess("d");
        playGuess("f");
        playGuess("g");
        playGuess("h");
        playGuess("i");
        playGuess("c");
        reportTest("win and loss", e0);
    endtask

    task automatic randomGames();
        word_t   w;
        letter_t g;
        int      e0;
        e0 = errors;
        for (int game = 0; game < RAND_GAMES; game++) begin
            for (int i = 0; i < WORD_LEN; i++) w[i*8 +: 8] = randomLetter();
            startGame(w);
            checkStatus("random word");
            for (int k = 0; k < RAND_GUESSES; k++) begin
                if (game == RAND_GAMES - 1 && k == RAND_GUESSES / 2) begin
                    // try a letter, restart mid game, then replay that letter
                    g = randomLetter();
                    playGuess(g);
                    for (int i = 0; i < WORD_LEN; i++) w[i*8 +: 8] = randomLetter();
                    startGame(w);
                    checkStatus("restart");
                    playGuess(g);
                end
                g = randomGuess();
                playGuess(g);
            end
        end
        reportTest("random games", e0);
    endtask

    initial begin
        nRst  = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        datIn = '0;
        foreach (expWord[i]) expWord[i] = '0;
        expFound    = '0;
        expMistakes = '0;
        expResult   = RES_NONE;
        expWon      = 1'b0;
        expLost     = 1'b0;
        expActive   = 1'b0;
        expTried    = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        nRst = 1'b1;

        afterReset();
        hitsAndMisses();
        repeatsAndInvalids();
        winAndLoss();
        randomGames();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the DUT stopped acknowledging", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

endmodule

/* filelist.f */
common/gamePkg.sv
hdl/wbGameRegs.sv
matcher/letterMatcher.sv
history/guessHistory.sv
hdl/gameControl.sv
hdl/wordGame.sv
dv/wordGameTb.sv

/* hdl/gameControl.sv */
/*
 * Game controller.
 * FSM that waits for the matcher and history results of each guess,
 * applies the scoring rules in priority order and keeps the found mask,
 * mistake count, last result and the won / lost / active flags.
 */
`timescale 1ns/1ps

module gameControl (
    input  logic               clk,
    input  logic               nRst,
    input  logic               newGame,
    input  logic               guessStrobe,
    input  logic               matchValid,
    input  logic               histValid,
    input  gamePkg::posMask_t  hitMask,
    input  logic               isRepeat,
    input  logic               isInvalid,
    output gamePkg::posMask_t  foundMask,
    output gamePkg::mistakes_t mistakes,
    output gamePkg::result_e   lastResult,
    output logic               won,
    output logic               lost,
    output logic               active,
    output logic               busy
);
    import gamePkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_RESULT,
        UPDATE,
        OVER
    } state_e;

    state_e    state, stateNext;
    posMask_t  foundNext;
    mistakes_t mistakesNext;
    result_e   resultNext;
    logic      wonNext, lostNext, activeNext;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state      <= IDLE;
            foundMask  <= '0;
            mistakes   <= '0;
            lastResult <= RES_NONE;
            won        <= 1'b0;
            lost       <= 1'b0;
            active     <= 1'b0;
        end else begin
            state      <= stateNext;
            foundMask  <= foundNext;
            mistakes   <= mistakesNext;
            lastResult <= resultNext;
            won        <= wonNext;
            lost       <= lostNext;
            active     <= activeNext;
        end
    end

    always_comb begin
        stateNext    = state;
        foundNext    = foundMask;
        mistakesNext = mistakes;
        resultNext   = lastResult;
        wonNext      = won;
        lostNext     = lost;
        activeNext   = active;

        case (state)
            IDLE, OVER: begin
                if (guessStrobe) stateNext = WAIT_RESULT;
            end
            WAIT_RESULT: begin
                if (matchValid && histValid) begin
                    stateNext = UPDATE;
                    // scoring rules, highest priority first
                    if (!active) begin
                        resultNext = RES_OVER;
                    end else if (isInvalid) begin
                        resultNext = RES_INVALID;
                    end else if (isRepeat) begin
                        resultNext = RES_REPEAT;
                    end else if (hitMask != '0) begin
                        foundNext  = foundMask | hitMask;
                        resultNext = RES_HIT;
                    end else begin
                        mistakesNext = mistakes + 1'b1;
                        resultNext   = RES_MISS;
                    end
                    if (active) begin
                        wonNext    = (foundNext == '1);
                        lostNext   = (mistakesNext == mistakes_t'(MAX_MISTAKES));
                        activeNext = !(wonNext || lostNext);
                    end
                end
            end
            UPDATE: begin
                stateNext = active ? IDLE : OVER;
            end
            default: stateNext = IDLE;
        endcase

        // a new word restarts everything
        if (newGame) begin
            stateNext    = IDLE;
            foundNext    = '0;
            mistakesNext = '0;
            resultNext   = RES_NONE;
            wonNext      = 1'b0;
            lostNext     = 1'b0;
            activeNext   = 1'b1;
        end
    end

    // covers the strobe cycle and the wait for results
    assign busy = guessStrobe || (state == WAIT_RESULT);

endmodule

/* hdl/wbGameRegs.sv */
/*
 * Wishbone classic slave of the word game.
 * Registered ack with back-pressure while a guess is in flight,
 * secret word storage over two registers, guess latch with strobe,
 * new game pulse and status word readback.
 */
`timescale 1ns/1ps

module wbGameRegs (
    input  logic              clk,
    input  logic              nRst,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  gamePkg::wbAddr_t  adr,
    input  gamePkg::wbData_t  datIn,
    output gamePkg::wbData_t  datOut,
    output logic              ack,
    output gamePkg::word_t    word,
    output gamePkg::letter_t  guess,
    output logic              guessStrobe,
    output logic              newGame,
    input  gamePkg::posMask_t foundMask,
    input  gamePkg::mistakes_t mistakes,
    input  gamePkg::result_e  lastResult,
    input  logic              won,
    input  logic              lost,
    input  logic              active,
    input  logic              busy
);
    import gamePkg::*;

    localparam int LW = $bits(letter_t);

    logic    access;
    logic    wrAccess;
    wbData_t statusWord;

    // one ack per cycle, none while a guess is being processed
    assign access   = cyc && stb && !ack && !busy;
    assign wrAccess = access && we;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            ack         <= 1'b0;
            guessStrobe <= 1'b0;
            newGame     <= 1'b0;
            word        <= '0;
        end else begin
            ack         <= access;
            guessStrobe <= wrAccess && (adr == ADDR_GUESS);
            newGame     <= wrAccess && (adr == ADDR_WORD1);
            if (wrAccess && adr == ADDR_WORD0) begin
                // letters 0 to 3
                word[4*LW-1:0] <= datIn;
            end
            if (wrAccess && adr == ADDR_WORD1) begin
                word[WORD_LEN*LW-1 -: LW] <= datIn[LW-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrAccess && adr == ADDR_GUESS) begin
            guess <= datIn[LW-1:0];
        end
    end

    // status word assembly
    always_comb begin
        statusWord = '0;
        statusWord[ST_FOUND_LSB +: WORD_LEN]             = foundMask;
        statusWord[ST_MISTAKES_LSB +: $bits(mistakes_t)] = mistakes;
        statusWord[ST_RESULT_LSB +: $bits(result_e)]     = lastResult;
        statusWord[ST_WON_BIT]                           = won;
        statusWord[ST_LOST_BIT]                          = lost;
        statusWord[ST_ACTIVE_BIT]                        = active;
    end

    // write-only registers read back as zero
    assign datOut = (adr == ADDR_STATUS) ? statusWord : '0;

endmodule

/* hdl/wordGame.sv */
/*
 * Word game engine top level.
 * Wishbone register block, letter matcher, guess history
 * and game controller.
 */
`timescale 1ns/1ps

module wordGame (
    input  logic             clk,
    input  logic             nRst,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  gamePkg::wbAddr_t adr,
    input  gamePkg::wbData_t datIn,
    output gamePkg::wbData_t datOut,
    output logic             ack
);
    import gamePkg::*;

    word_t     word;
    letter_t   guess;
    logic      guessStrobe;
    logic      newGame;
    posMask_t  hitMask;
    logic      matchValid;
    logic      isRepeat;
    logic      isInvalid;
    logic      histValid;
    posMask_t  foundMask;
    mistakes_t mistakes;
    result_e   lastResult;
    logic      won, lost, active, busy;

    wbGameRegs u_wbGameRegs (
        .clk(clk), .nRst(nRst),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datIn(datIn), .datOut(datOut), .ack(ack),
        .word(word), .guess(guess),
        .guessStrobe(guessStrobe), .newGame(newGame),
        .foundMask(foundMask), .mistakes(mistakes), .lastResult(lastResult),
        .won(won), .lost(lost), .active(active), .busy(busy)
    );

    // both classifiers run on the same strobe
    letterMatcher u_letterMatcher (
        .clk(clk), .nRst(nRst),
        .word(word), .guess(guess), .guessStrobe(guessStrobe),
        .hitMask(hitMask), .matchValid(matchValid)
    );

    guessHistory u_guessHistory (
        .clk(clk), .nRst(nRst),
        .guess(guess), .guessStrobe(guessStrobe), .newGame(newGame),
        .isRepeat(isRepeat), .isInvalid(isInvalid), .histValid(histValid)
    );

    gameControl u_gameControl (
        .clk(clk), .nRst(nRst),
        .newGame(newGame), .guessStrobe(guessStrobe),
        .matchValid(matchValid), .histValid(histValid),
        .hitMask(hitMask), .isRepeat(isRepeat), .isInvalid(isInvalid),
        .foundMask(foundMask), .mistakes(mistakes), .lastResult(lastResult),
        .won(won), .lost(lost), .active(active), .busy(busy)
    );

endmodule

/* history/guessHistory.sv */
/*
 * Guess history.
 * Keeps the set of letters tried in the current game,
 * flags repeated letters and anything outside a to z,
 * and clears on a new game.
 */
`timescale 1ns/1ps

module guessHistory (
    input  logic             clk,
    input  logic             nRst,
    input  gamePkg::letter_t guess,
    input  logic             guessStrobe,
    input  logic             newGame,
    output logic             isRepeat,
    output logic             isInvalid,
    output logic             histValid
);
    import gamePkg::*;

    localparam int IDX_W = $clog2(ALPHA_LEN);

    alphaMask_t          tried;
    logic                inRange;
    letter_t             offset;
    logic [IDX_W-1:0]    letterIdx;

    assign inRange   = (guess >= LETTER_A) && (guess <= LETTER_Z);
    assign offset    = guess - LETTER_A;
    // only meaningful when inRange
    assign letterIdx = offset[IDX_W-1:0];

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            tried     <= '0;
            isRepeat  <= 1'b0;
            isInvalid <= 1'b0;
            histValid <= 1'b0;
        end else begin
            histValid <= guessStrobe;
            if (newGame) begin
                tried     <= '0;
                isRepeat  <= 1'b0;
                isInvalid <= 1'b0;
            end else if (guessStrobe) begin
                isInvalid <= !inRange;
                isRepeat  <= inRange && tried[letterIdx];
                // invalid bytes are not recorded
                if (inRange) begin
                    tried[letterIdx] <= 1'b1;
                end
            end
        end
    end

endmodule

/* matcher/letterMatcher.sv */
/*
 * Letter matcher.
 * Compares a guess letter against all five word positions
 * in parallel and registers the hit mask with a one-cycle valid.
 */
`timescale 1ns/1ps

module letterMatcher (
    input  logic              clk,
    input  logic              nRst,
    input  gamePkg::word_t    word,
    input  gamePkg::letter_t  guess,
    input  logic              guessStrobe,
    output gamePkg::posMask_t hitMask,
    output logic              matchValid
);
    import gamePkg::*;

    localparam int LW = $bits(letter_t);

    posMask_t hitNext;

    // one comparator per position
    always_comb begin
        for (int i = 0; i < WORD_LEN; i++) begin
            hitNext[i] = (word[i*LW +: LW] == guess);
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            matchValid <= 1'b0;
        end else begin
            matchValid <= guessStrobe;
        end
    end

    // mask only moves on a new guess
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            hitMask <= '0;
        end else if (guessStrobe) begin
            hitMask <= hitNext;
        end
    end

endmodule
